// ==== common/simon_pkg.sv ====
/* Simon game shared types */

`default_nettype none

package simon_pkg;

  // Colour buttons on ui_in[3:0]
  localparam int num_buttons = 4;

  // Colour code, also the lamp index on uo_out[3:0]
  typedef enum logic [1:0] {
    red    = 2'd0,  // uo_out[0]
    green  = 2'd1,  // uo_out[1]
    blue   = 2'd2,  // uo_out[2]
    yellow = 2'd3   // uo_out[3]
  } color_t;

  // Game controller FSM
  typedef enum logic [2:0] {
    idle       = 3'd0,  // After reset, waits for start
    extend     = 3'd1,  // Append one random colour
    show_on    = 3'd2,  // Lamp lit
    show_off   = 3'd3,  // Dark gap after each lamp
    wait_input = 3'd4,  // Player repeats the pattern
    game_lose  = 3'd5,  // Wrong press, hold lose
    game_win   = 3'd6   // Full depth done, hold win
  } game_state_t;

endpackage

`default_nettype wire

// ==== io_sync/io_sync.sv ====
/* Button synchronizer and debouncer */

`timescale 1ns/1ps
`default_nettype none

module io_sync #(
  parameter int debounce_cycles = 16
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [simon_pkg::num_buttons-1:0] buttons,
  input  logic                             start,
  output logic                             press_valid,
  output simon_pkg::color_t                press_color,
  output logic                             start_pulse
);
  import simon_pkg::*;

  localparam int cw = $clog2(debounce_cycles + 1);

  logic [num_buttons-1:0] btn_meta;
  logic [num_buttons-1:0] btn_sync;
  logic [num_buttons-1:0] btn_last;   // Previous synced level
  logic [cw-1:0]          btn_cnt;
  logic                   btn_stable;
  logic                   btn_armed;  // All released seen
  logic                   btn_single;
  color_t                 btn_color;
  logic                   start_meta;
  logic                   start_sync;
  logic                   start_last;
  logic [cw-1:0]          start_cnt;
  logic                   start_stable;
  logic                   start_armed;

  // Two-flop synchronizers plus one delay for change detect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn_meta   <= '0;
      btn_sync   <= '0;
      btn_last   <= '0;
      start_meta <= 1'b0;
      start_sync <= 1'b0;
      start_last <= 1'b0;
    end else begin
      btn_meta   <= buttons;
      btn_sync   <= btn_meta;
      btn_last   <= btn_sync;
      start_meta <= start;
      start_sync <= start_meta;
      start_last <= start_sync;
    end
  end

  // Counter lags a level change by one cycle
  assign btn_stable   = (btn_cnt == cw'(debounce_cycles)) && (btn_sync == btn_last);
  assign start_stable = (start_cnt == cw'(debounce_cycles)) && (start_sync == start_last);

  // Stability counters, restart on any level change
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn_cnt   <= '0;
      start_cnt <= '0;
    end else begin
      if (btn_sync != btn_last) btn_cnt <= '0;
      else if (!btn_stable) btn_cnt <= btn_cnt + cw'(1);  // Saturate at limit
      if (start_sync != start_last) start_cnt <= '0;
      else if (!start_stable) start_cnt <= start_cnt + cw'(1);
    end
  end

  // One-hot to colour, chords give no press
  always_comb begin
    btn_single = 1'b1;
    btn_color  = red;
    case (btn_sync)
      4'b0001: btn_color = red;
      4'b0010: btn_color = green;
      4'b0100: btn_color = blue;
      4'b1000: btn_color = yellow;
      default: btn_single = 1'b0;
    endcase
  end

  // Press and start events, re-armed only by a stable release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn_armed   <= 1'b0;
      press_valid <= 1'b0;
      start_armed <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      press_valid <= 1'b0;
      start_pulse <= 1'b0;
      if (btn_stable) begin
        if (btn_sync == '0) begin
          btn_armed <= 1'b1;
        end else if (btn_armed) begin
          btn_armed   <= 1'b0;        // Chord also disarms
          press_valid <= btn_single;
        end
      end
      if (start_stable) begin
        if (!start_sync) begin
          start_armed <= 1'b1;
        end else if (start_armed) begin
          start_armed <= 1'b0;
          start_pulse <= 1'b1;        // Rising edge event
        end
      end
    end
  end

  // Colour payload, valid alongside press_valid
  always_ff @(posedge clk) begin
    if (btn_stable && btn_single) press_color <= btn_color;
  end

endmodule : io_sync

`default_nettype wire

// ==== design/rng.sv ====
/* Random colour LFSR */

`timescale 1ns/1ps
`default_nettype none

module rng (
  input  logic              clk,
  input  logic              rst_n,
  output simon_pkg::color_t rand_color
);
  import simon_pkg::*;

  logic [15:0] lfsr;
  logic        feedback;

  // Taps 16, 14, 13, 11 for maximal length
  assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr <= 16'hACE1;  // Any nonzero seed
    end else begin
      lfsr <= {lfsr[14:0], feedback};  // Steps every cycle
    end
  end

  // Low two bits as the colour
  assign rand_color = color_t'(lfsr[1:0]);

endmodule : rng

`default_nettype wire

// ==== design/seq_mem.sv ====
/* Colour sequence memory */

`timescale 1ns/1ps
`default_nettype none

module seq_mem #(
  parameter int depth = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(depth)-1:0] wr_addr,
  input  simon_pkg::color_t        wr_color,
  input  logic [$clog2(depth)-1:0] rd_addr,
  output simon_pkg::color_t        rd_color
);
  import simon_pkg::*;

  // One colour per round position
  color_t mem [depth];

  // Synchronous write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_color;
    end
  end

  // Read is combinational, no latency
  assign rd_color = mem[rd_addr];

endmodule : seq_mem

`default_nettype wire

// ==== design/lamp_timer.sv ====
/* Lamp on and gap timer */

`timescale 1ns/1ps
`default_nettype none

module lamp_timer #(
  parameter int lamp_cycles = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic timer_start,
  output logic timer_done
);

  localparam int cw = $clog2(lamp_cycles + 1);

  logic [cw-1:0] count;  // Cycles left before done
  logic          busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
      busy  <= 1'b0;
    end else if (timer_start) begin
      count <= cw'(lamp_cycles - 1);  // Start wins over a pending done
      busy  <= 1'b1;
    end else if (busy) begin
      if (count == '0) busy <= 1'b0;
      else count <= count - cw'(1);
    end
  end

  // Done lamp_cycles cycles after start
  assign timer_done = busy && (count == '0);

endmodule : lamp_timer

`default_nettype wire

// ==== controller/controller.sv ====
/* Simon game controller */

`timescale 1ns/1ps
`default_nettype none

module controller #(
  parameter int depth = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     press_valid,
  input  simon_pkg::color_t        press_color,
  input  logic                     start_pulse,
  input  simon_pkg::color_t        rand_color,
  input  simon_pkg::color_t        rd_color,
  input  logic                     timer_done,
  output logic                     wr_en,
  output logic [$clog2(depth)-1:0] wr_addr,
  output simon_pkg::color_t        wr_color,
  output logic [$clog2(depth)-1:0] rd_addr,
  output logic                     timer_start,
  output logic                     lamp_ena,
  output simon_pkg::color_t        lamp_color,
  output logic                     lose,
  output logic                     win,
  output logic                     hs
);
  import simon_pkg::*;

  localparam int aw = $clog2(depth);      // Memory address
  localparam int sw = $clog2(depth + 1);  // Round length and score

  game_state_t   state;
  logic [sw-1:0] round_len;   // Colours in the current pattern
  logic [aw-1:0] pos;         // Position within the round
  logic [sw-1:0] best_score;
  logic [sw-1:0] end_score;   // Score if this press ends the game
  logic          last_pos;
  logic          final_round;
  logic          press_ok;
  logic          game_over;
  logic          new_best;

  assign last_pos    = (sw'(pos) + sw'(1)) == round_len;
  assign final_round = round_len == sw'(depth);
  assign press_ok    = press_color == rd_color;

  // Wrong press scores round-1, finishing the last round scores depth
  assign end_score = press_ok ? round_len : round_len - sw'(1);
  assign game_over = (state == wait_input) && press_valid &&
                     (!press_ok || (last_pos && final_round));
  assign new_best  = end_score > best_score;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      round_len  <= '0;
      pos        <= '0;
      best_score <= '0;
      lose       <= 1'b0;
      win        <= 1'b0;
      hs         <= 1'b0;
    end else begin
      unique case (state)
        idle, game_lose, game_win: begin
          if (start_pulse) begin       // New game, flags cleared
            state     <= extend;
            round_len <= '0;
            pos       <= '0;
            lose      <= 1'b0;
            win       <= 1'b0;
            hs        <= 1'b0;
          end
        end
        extend: begin
          round_len <= round_len + sw'(1);  // New colour written this cycle
          pos       <= '0;
          state     <= show_on;
        end
        show_on: begin
          if (timer_done) state <= show_off;
        end
        show_off: begin
          if (timer_done) begin
            if (last_pos) begin
              pos   <= '0;
              state <= wait_input;
            end else begin
              pos   <= pos + aw'(1);
              state <= show_on;
            end
          end
        end
        wait_input: begin
          if (press_valid) begin
            if (!press_ok) begin
              state <= game_lose;
              lose  <= 1'b1;
            end else if (!last_pos) begin
              pos <= pos + aw'(1);
            end else if (final_round) begin
              state <= game_win;
              win   <= 1'b1;
            end else begin
              state <= extend;          // Next round
            end
          end
        end
        default: state <= idle;
      endcase

      // Best score kept across games
      if (game_over) begin
        hs <= new_best;
        if (new_best) best_score <= end_score;
      end
    end
  end

  assign wr_en      = state == extend;
  assign wr_addr    = round_len[aw-1:0];  // Append after the last colour
  assign wr_color   = rand_color;
  assign rd_addr    = pos;
  assign lamp_ena   = state == show_on;
  assign lamp_color = rd_color;

  // Load timer for each lamp and each gap except the final gap's end
  assign timer_start = (state == extend) ||
                       (timer_done && ((state == show_on) ||
                                       ((state == show_off) && !last_pos)));

endmodule : controller

`default_nettype wire

// ==== design/simon_top.sv ====
/* Simon game top level */

`timescale 1ns/1ps
`default_nettype none

module simon_top #(
  parameter int depth           = 16,
  parameter int lamp_cycles     = 2_500_000,
  parameter int debounce_cycles = 50_000
) (
  input  logic [7:0] ui_in,    // [3:0] colours, [5] start
  output logic [7:0] uo_out,   // [3:0] lamps, [4] hs, [5] lose, [6] win
  input  logic [7:0] uio_in,   // Unused
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic       ena,      // Ignored
  input  logic       clk,
  input  logic       rst_n
);
  import simon_pkg::*;

  localparam int aw = $clog2(depth);

  logic                   press_valid;
  color_t                 press_color;
  logic                   start_pulse;
  color_t                 rand_color;
  logic                   wr_en;
  logic [aw-1:0]          wr_addr;
  color_t                 wr_color;
  logic [aw-1:0]          rd_addr;
  color_t                 rd_color;
  logic                   timer_start;
  logic                   timer_done;
  logic                   lamp_ena;
  color_t                 lamp_color;
  logic                   lose;
  logic                   win;
  logic                   hs;
  logic [num_buttons-1:0] lamps;

  // Bidirectional pins unused
  assign uio_out = '0;
  assign uio_oe  = '0;

  // Colour code to one-hot lamp
  always_comb begin
    lamps = '0;
    if (lamp_ena) lamps[lamp_color] = 1'b1;
  end

  assign uo_out = {1'b0, win, lose, hs, lamps};

  io_sync #(
    .debounce_cycles ( debounce_cycles )
  ) io_sync_u1 (
    .clk         ( clk                    ),
    .rst_n       ( rst_n                  ),
    .buttons     ( ui_in[num_buttons-1:0] ),
    .start       ( ui_in[5]               ),
    .press_valid ( press_valid            ),
    .press_color ( press_color            ),
    .start_pulse ( start_pulse            )
  );

  rng rng_u1 (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .rand_color ( rand_color )
  );

  seq_mem #(
    .depth ( depth )
  ) seq_mem_u1 (
    .clk      ( clk      ),
    .wr_en    ( wr_en    ),
    .wr_addr  ( wr_addr  ),
    .wr_color ( wr_color ),
    .rd_addr  ( rd_addr  ),
    .rd_color ( rd_color )
  );

  lamp_timer #(
    .lamp_cycles ( lamp_cycles )
  ) lamp_timer_u1 (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .timer_start ( timer_start ),
    .timer_done  ( timer_done  )
  );

  controller #(
    .depth ( depth )
  ) controller_u1 (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .press_valid ( press_valid ),
    .press_color ( press_color ),
    .start_pulse ( start_pulse ),
    .rand_color  ( rand_color  ),
    .rd_color    ( rd_color    ),
    .timer_done  ( timer_done  ),
    .wr_en       ( wr_en       ),
    .wr_addr     ( wr_addr     ),
    .wr_color    ( wr_color    ),
    .rd_addr     ( rd_addr     ),
    .timer_start ( timer_start ),
    .lamp_ena    ( lamp_ena    ),
    .lamp_color  ( lamp_color  ),
    .lose        ( lose        ),
    .win         ( win         ),
    .hs          ( hs          )
  );

endmodule : simon_top

`default_nettype wire

// ==== dv/simon_properties.sv ====
/* Simon pin assertions */

`timescale 1ns/1ps
`default_nettype none

module simon_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic [7:0]             uo_out,
  input logic [7:0]             uio_out,
  input logic [7:0]             uio_oe,
  input simon_pkg::game_state_t state
);
  import simon_pkg::*;

  lamps_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(uo_out[3:0]))
    else $error("More than one lamp lit");

  // Game ends one way only
  lose_win_excl: assert property (@(posedge clk) disable iff (!rst_n) !(uo_out[5] && uo_out[6]))
    else $error("lose and win both high");

  unused_pins_zero: assert property (@(posedge clk) uio_out == 8'h0 && uio_oe == 8'h0 && !uo_out[7])
    else $error("Unused output pin driven");

  dark_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    state == wait_input |-> uo_out[3:0] == 4'b0)
    else $error("Lamp lit while waiting for input");

endmodule : simon_properties

bind simon_top simon_properties simon_properties_u1 (
  .clk     ( clk                 ),
  .rst_n   ( rst_n               ),
  .uo_out  ( uo_out              ),
  .uio_out ( uio_out             ),
  .uio_oe  ( uio_oe              ),
  .state   ( controller_u1.state )
);

`default_nettype wire

// ==== dv/simon_tb.sv ====
/* Simon game testbench */

`timescale 1ns/1ps
`default_nettype none

module simon_tb;
  import simon_pkg::*;

  localparam int depth           = 4;
  localparam int lamp_cycles     = 8;
  localparam int debounce_cycles = 3;
  localparam int hold_cycles     = debounce_cycles + 4;  // Press and release time
  localparam int num_games       = 3;
  // Playback plus replay of rounds 1..depth, gaps, start and one chord
  localparam int game_cycles = (depth * (depth + 1) / 2) * (2 * lamp_cycles + 2 * hold_cycles)
                             + depth * (lamp_cycles + 4) + 6 * hold_cycles;
  localparam int max_cycles  = 16 + 20 + num_games * game_cycles + 400;

  logic        clk;
  logic        rst_n;
  logic [7:0]  ui_in;
  logic [7:0]  uio_in;
  logic        ena;
  wire  [7:0]  uo_out;
  wire  [7:0]  uio_out;
  wire  [7:0]  uio_oe;

  int          lamp_log[$];      // Every lamp lit, as colour index
  int          pattern[$];       // Colours seen so far in this game
  logic [3:0]  prev_lamps;
  int          best_score;       // Reference best score
  int          cycle_count = 0;
  logic [31:0] lcg_state;

  simon_top #(
    .depth           ( depth           ),
    .lamp_cycles     ( lamp_cycles     ),
    .debounce_cycles ( debounce_cycles )
  ) dut (
    .ui_in   ( ui_in   ),
    .uo_out  ( uo_out  ),
    .uio_in  ( uio_in  ),
    .uio_out ( uio_out ),
    .uio_oe  ( uio_oe  ),
    .ena     ( ena     ),
    .clk     ( clk     ),
    .rst_n   ( rst_n   )
  );

  always #2 clk = ~clk;  // 4 ns period

  // Reference for the high-score flag
  function automatic logic expected_hs(input int score, input int best);
    return score > best;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // One-hot lamp to colour code
  function automatic int lamp_index(input logic [3:0] lamps);
    int idx;
    idx = -1;
    for (int i = 0; i < 4; i++) begin
      if (lamps[i]) idx = i;
    end
    return idx;
  endfunction

  task automatic check(input int actual, input int expected, input string msg);
    if (actual != expected) begin
      $display("FAIL %0t ns: %s (got %0d, expected %0d)", $time, msg, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Lamp monitor, logs each lamp as it lights
  always @(negedge clk) begin
    if (!rst_n) begin
      prev_lamps <= '0;
    end else begin
      check(($countones(uo_out[3:0]) <= 1) ? 1 : 0, 1, "more than one lamp lit");
      if (uo_out[3:0] != 4'b0 && prev_lamps == 4'b0) lamp_log.push_back(lamp_index(uo_out[3:0]));
      prev_lamps <= uo_out[3:0];
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, the game never reached the expected state",
               cycle_count);
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout");
    end
  end

  task automatic press_buttons(input logic [3:0] mask);
    @(negedge clk);
    ui_in[3:0] = mask;
    repeat (hold_cycles) @(negedge clk);
    ui_in[3:0] = 4'b0;  // Release rearms the debouncer
    repeat (hold_cycles) @(negedge clk);
  endtask

  // One-cycle bounce, far shorter than the debounce time
  task automatic glitch_button(input logic [3:0] mask);
    @(negedge clk);
    ui_in[3:0] = mask;
    @(negedge clk);
    ui_in[3:0] = 4'b0;
    repeat (hold_cycles) @(negedge clk);
  endtask

  task automatic press_start();
    @(negedge clk);
    ui_in[5] = 1'b1;
    repeat (hold_cycles) @(negedge clk);
    ui_in[5] = 1'b0;
    repeat (hold_cycles) @(negedge clk);
  endtask

  // Wait out playback of round n, then compare against earlier rounds
  task automatic watch_round(input int base, input int n);
    while (lamp_log.size() < base + n) @(posedge clk);
    @(negedge clk);
    while (uo_out[3:0] != 4'b0) @(negedge clk);
    repeat (lamp_cycles + 2) @(negedge clk);  // Final dark gap
    check(lamp_log.size() - base, n, $sformatf("colours played in round %0d", n));
    for (int i = 0; i < n - 1; i++) begin
      check(lamp_log[base + i], pattern[i],
            $sformatf("round %0d colour %0d differs from round %0d", n, i, n - 1));
    end
    pattern.push_back(lamp_log[base + n - 1]);  // Newly appended colour
  endtask

  // wrong_round 0 plays to a win
  task automatic play_game(input int wrong_round, input logic chord_check);
    int base;
    int score;
    base = lamp_log.size();
    pattern.delete();
    press_start();
    check(int'(uo_out[6:4]), 0, "flags not cleared by start");
    for (int n = 1; n <= depth; n++) begin
      watch_round(base, n);
      base += n;
      if (chord_check && n == 2) begin
        glitch_button(4'(1 << ((pattern[0] + 1) % 4)));  // Bounce of a wrong colour
        check(int'(uo_out[5]), 0, "short glitch counted as a press");
        press_buttons(4'b0101);  // Two buttons at once
        check(int'(dut.controller_u1.state), int'(wait_input), "chord left wait_input");
        check(int'(uo_out[5]), 0, "chord raised lose");
        check(lamp_log.size(), base, "chord started playback");
      end
      if (n == wrong_round) begin
        press_buttons(4'(1 << ((pattern[0] + 1) % 4)));  // Not the first colour
        break;
      end
      for (int i = 0; i < n; i++) begin
        press_buttons(4'(1 << pattern[i]));
      end
    end
    while (uo_out[6:5] == 2'b0) @(negedge clk);
    score = (wrong_round == 0) ? depth : wrong_round - 1;
    check(int'(uo_out[5]), (wrong_round != 0) ? 1 : 0, "lose flag");
    check(int'(uo_out[6]), (wrong_round == 0) ? 1 : 0, "win flag");
    check(int'(uo_out[4]), int'(expected_hs(score, best_score)),
          $sformatf("hs for score %0d, best %0d", score, best_score));
    if (score > best_score) best_score = score;
  endtask

  initial begin
    int wrong_round;
    clk        = 1'b0;
    rst_n      = 1'b0;
    ui_in      = '0;
    uio_in     = '0;
    ena        = 1'b1;
    best_score = 0;
    lcg_state  = 32'd83506;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (20) begin  // Quiet until start
      @(negedge clk);
      check(int'(uo_out), 0, "output active before start");
    end
    check(lamp_log.size(), 0, "lamp lit before start");

    // Early loss, first nonzero score sets hs
    lcg_state   = lcg_next(lcg_state);
    wrong_round = 2 + int'(lcg_state[30:16]) % (depth - 1);
    play_game(wrong_round, 1'b0);

    play_game(0, 1'b1);  // Full win with a chord in round 2

    // Lower score than the win
    lcg_state   = lcg_next(lcg_state);
    wrong_round = 1 + int'(lcg_state[30:16]) % depth;
    play_game(wrong_round, 1'b0);
    check(int'(uo_out[4]), 0, "hs after a lower score");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : simon_tb

`default_nettype wire

// ==== project.f ====
common/simon_pkg.sv
io_sync/io_sync.sv
design/rng.sv
design/seq_mem.sv
design/lamp_timer.sv
controller/controller.sv
design/simon_top.sv
dv/simon_properties.sv
dv/simon_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Simon testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module simon_tb -o simon_sim &&
./obj_dir/simon_sim || exit 1
